//--- segway_sense_pkg.sv
package segway_sense_pkg;

	// sample and load widths
	typedef logic [11:0] ld_t;		// one a2d sample, also a single load cell reading
	typedef logic [12:0] ld_sum_t;	// left plus right, carry kept
	typedef logic [2:0]  chnl_t;	// a2d mux channel

	// a2d channel map on the sensor board
	localparam chnl_t LFT_CHNL  = 3'd0;
	localparam chnl_t RGHT_CHNL = 3'd4;
	localparam chnl_t BATT_CHNL = 3'd5;

	// rider present once the summed load is above this
	localparam ld_sum_t MIN_RIDER_WEIGHT = 13'h200;

	// battery divider thresholds, hysteresis band between them
	localparam ld_t BATT_LOW_ON  = 12'h980;	// below this flag goes up
	localparam ld_t BATT_LOW_OFF = 12'hA00;	// at or above this flag goes down

	// settle timer
	localparam int TMR_W = 26;
	localparam logic [TMR_W-1:0] TMR_FULL_REAL = 26'h3DFD240;	// 1.3 s of 50 MHz clk
	localparam logic [TMR_W-1:0] TMR_FULL_FAST = 26'h0007FFF;	// short settle for sim

	// spi clocking, clk cycles per sclk half period
	localparam int SCLK_DIV = 2;

	// cycles between battery conversions
	localparam int BATT_PERIOD = 1024;

	// what a requester hands to the a2d master
	typedef struct packed {
		chnl_t chnl;	// channel to convert
	} a2d_req_t;

	// rider presence states
	typedef enum logic [1:0] {
		IDLE,		// nobody on board
		WAIT,		// weight seen, waiting for rider to settle
		STEER_EN	// rider settled, steering allowed
	} steer_state_t;

endpackage

//--- a2d_spi.sv
`timescale 1ns/1ps
module a2d_spi (
	input  logic clk,
	input  logic rst_n,
	input  logic strt,								// one cycle kick from the arbiter
	input  segway_sense_pkg::a2d_req_t req,		// channel, sampled with strt
	output logic ss_n,
	output logic sclk,
	output logic mosi,
	input  logic miso,
	output logic done,								// one cycle, res valid with it
	output segway_sense_pkg::ld_t res
);

	typedef enum logic [1:0] {
		S_IDLE,		// bus parked, ss_n and sclk high
		S_FRONT,	// ss_n low, first command bit on mosi
		S_SHIFT,	// 16 sclk periods
		S_BACK		// frame over, done shows here
	} spi_state_t;

	spi_state_t state;
	logic [$clog2(2 * segway_sense_pkg::SCLK_DIV)-1:0] div_cnt;	// position inside one sclk period
	logic [3:0] bit_cnt;	// which sclk period of the frame
	logic [15:0] shft;		// command leaves from the top, result enters at the bottom
	logic miso_smp;			// miso caught at the rising sclk edge
	logic rise;				// sclk goes high on this edge
	logic fall;				// end of period, sclk goes low on this edge
	logic last_bit;

	assign rise = (int'(div_cnt) == segway_sense_pkg::SCLK_DIV - 1);
	assign fall = (int'(div_cnt) == 2 * segway_sense_pkg::SCLK_DIV - 1);
	assign last_bit = &bit_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else begin
			case (state)
				S_IDLE: if (strt) state <= S_FRONT;
				S_FRONT: begin
					state <= S_SHIFT;	// single set-up cycle
					div_cnt <= '0;
					bit_cnt <= '0;
				end
				S_SHIFT: begin
					if (fall) begin
						div_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;	// wraps to 0 after bit 15
						if (last_bit)
							state <= S_BACK;
					end else begin
						div_cnt <= div_cnt + 1'b1;
					end
				end
				default: state <= S_IDLE;	// back porch lasts one cycle
			endcase
		end
	end

	// command is 2 zero bits, channel in bits 13..11, rest don't care
	always_ff @(posedge clk) begin
		if (state == S_IDLE && strt)
			shft <= {2'b00, req.chnl, 11'h000};
		else if (state == S_SHIFT && fall)
			shft <= {shft[14:0], miso_smp};	// mosi moves on the falling edge
	end

	always_ff @(posedge clk) begin
		if (state == S_SHIFT && rise)
			miso_smp <= miso;
	end

	assign ss_n = ~(state == S_FRONT || state == S_SHIFT);
	assign sclk = ~(state == S_SHIFT && int'(div_cnt) < segway_sense_pkg::SCLK_DIV);	// low half first
	assign mosi = shft[15];
	assign done = (state == S_BACK);
	assign res = shft[11:0];	// last 12 bits of the frame

	// the arbiter must wait for done before it kicks again
	strt_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		strt |-> state == S_IDLE);

endmodule

//--- a2d_arbiter.sv
`timescale 1ns/1ps
module a2d_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  logic ld_req,							// load cell poller wants the bus
	input  logic batt_req,							// battery monitor wants the bus
	input  segway_sense_pkg::a2d_req_t ld_chnl,
	input  segway_sense_pkg::a2d_req_t batt_chnl,
	output logic strt,								// one cycle kick to the spi master
	output segway_sense_pkg::a2d_req_t req,
	input  logic done,
	output logic ld_done,
	output logic batt_done
);

	logic busy;			// grant held until the master reports done
	logic owner;		// 0 load cells, 1 battery
	logic last_batt;	// battery finished the previous frame
	logic pick_batt;	// who gets the next grant

	// round robin, only matters when both are waiting
	assign pick_batt = batt_req & (~ld_req | ~last_batt);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			owner <= 1'b0;
			last_batt <= 1'b1;	// load cells go first out of reset
			strt <= 1'b0;
		end else begin
			strt <= 1'b0;
			if (busy) begin
				if (done) begin
					busy <= 1'b0;	// one idle cycle follows
					last_batt <= owner;
				end
			end else if (ld_req || batt_req) begin
				busy <= 1'b1;
				strt <= 1'b1;
				owner <= pick_batt;
			end
		end
	end

	assign req = owner ? batt_chnl : ld_chnl;	// stable from strt onward
	assign ld_done = done & ~owner;
	assign batt_done = done & owner;

	one_done_at_a_time: assert property (@(posedge clk) disable iff (!rst_n)
		!(ld_done && batt_done));

	// requesters keep req up until their own done
	owner_still_waiting: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> (owner ? batt_req : ld_req));

endmodule

//--- ld_cell_poll.sv
`timescale 1ns/1ps
module ld_cell_poll (
	input  logic clk,
	input  logic rst_n,
	output logic req,								// held high, poller never rests
	output segway_sense_pkg::a2d_req_t chnl,
	input  logic done,								// our own conversion finished
	input  segway_sense_pkg::ld_t res,
	output segway_sense_pkg::ld_t lft_ld,
	output segway_sense_pkg::ld_t rght_ld,
	output logic ld_vld							// pulses when a fresh pair is in
);

	logic sel_rght;		// right cell is the one being converted

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
			sel_rght <= 1'b0;	// left first
			lft_ld <= '0;
			rght_ld <= '0;
			ld_vld <= 1'b0;
		end else begin
			req <= 1'b1;						// back to back polling
			ld_vld <= done & sel_rght;			// right always closes a pair
			if (done) begin
				sel_rght <= ~sel_rght;
				if (sel_rght)
					rght_ld <= res;
				else
					lft_ld <= res;
			end
		end
	end

	// channel flips the cycle after done, before the next strt
	assign chnl.chnl = sel_rght ? segway_sense_pkg::RGHT_CHNL : segway_sense_pkg::LFT_CHNL;

endmodule

//--- batt_mon.sv
`timescale 1ns/1ps
module batt_mon (
	input  logic clk,
	input  logic rst_n,
	output logic req,
	output segway_sense_pkg::a2d_req_t chnl,
	input  logic done,
	input  segway_sense_pkg::ld_t res,
	output logic batt_low
);

	logic [$clog2(segway_sense_pkg::BATT_PERIOD)-1:0] intvl_cnt;	// time since last request
	logic intvl_end;

	assign intvl_end = (int'(intvl_cnt) == segway_sense_pkg::BATT_PERIOD - 1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			intvl_cnt <= '0;
			req <= 1'b0;
			batt_low <= 1'b0;
		end else begin
			intvl_cnt <= intvl_end ? '0 : intvl_cnt + 1'b1;
			if (intvl_end)
				req <= 1'b1;		// a late grant just keeps it pending
			else if (done)
				req <= 1'b0;
			// hysteresis, between the thresholds nothing changes
			if (done) begin
				if (res < segway_sense_pkg::BATT_LOW_ON)
					batt_low <= 1'b1;
				else if (res >= segway_sense_pkg::BATT_LOW_OFF)
					batt_low <= 1'b0;
			end
		end
	end

	assign chnl.chnl = segway_sense_pkg::BATT_CHNL;	// only ever the divider

endmodule

//--- steer_en.sv
`timescale 1ns/1ps
module steer_en #(
	parameter bit fast_sim = 1'b0	// short settle timer for sim
) (
	input  logic clk,
	input  logic rst_n,
	input  segway_sense_pkg::ld_t lft_ld,
	input  segway_sense_pkg::ld_t rght_ld,
	output segway_sense_pkg::ld_t ld_cell_diff,	// left minus right, two's complement
	output logic en_steer,
	output logic rider_off							// one cycle when the rider leaves
);

	segway_sense_pkg::steer_state_t state, nxt_state;
	segway_sense_pkg::ld_sum_t ld_sum;		// both cells, carry kept
	segway_sense_pkg::ld_sum_t sum_1_4;
	segway_sense_pkg::ld_sum_t sum_15_16;
	segway_sense_pkg::ld_sum_t diff_abs;	// magnitude widened to compare with sums
	segway_sense_pkg::ld_t diff_mag;
	logic [segway_sense_pkg::TMR_W-1:0] tmr;		// settle timer
	logic [segway_sense_pkg::TMR_W-1:0] tmr_lim;
	logic sum_gt_min, sum_lt_min;
	logic diff_gt_1_4;		// rider not yet centered
	logic diff_gt_15_16;	// rider stepping off one side
	logic tmr_full;
	logic clr_tmr;

	assign ld_sum = {1'b0, lft_ld} + {1'b0, rght_ld};
	assign ld_cell_diff = lft_ld - rght_ld;
	assign diff_mag = ld_cell_diff[11] ? (~ld_cell_diff + 1'b1) : ld_cell_diff;
	assign diff_abs = {1'b0, diff_mag};
	assign sum_1_4 = ld_sum >> 2;
	assign sum_15_16 = ld_sum - (ld_sum >> 4);

	assign sum_gt_min = (ld_sum > segway_sense_pkg::MIN_RIDER_WEIGHT);
	assign sum_lt_min = (ld_sum < segway_sense_pkg::MIN_RIDER_WEIGHT);	// equal is neither
	assign diff_gt_1_4 = (diff_abs > sum_1_4);
	assign diff_gt_15_16 = (diff_abs > sum_15_16);

	assign tmr_lim = fast_sim ? segway_sense_pkg::TMR_FULL_FAST : segway_sense_pkg::TMR_FULL_REAL;
	assign tmr_full = (tmr >= tmr_lim);

	// saturates at the limit so a long wait never wraps
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tmr <= '0;
		else if (clr_tmr)
			tmr <= '0;
		else if (!tmr_full)
			tmr <= tmr + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= segway_sense_pkg::IDLE;
		else
			state <= nxt_state;
	end

	always_comb begin
		nxt_state = state;
		clr_tmr = 1'b0;
		en_steer = 1'b0;
		rider_off = 1'b0;
		case (state)
			segway_sense_pkg::WAIT: begin
				if (sum_lt_min) begin
					nxt_state = segway_sense_pkg::IDLE;
					rider_off = 1'b1;	// got off before settling
				end else if (diff_gt_1_4) begin
					clr_tmr = 1'b1;		// still shifting around, restart settle
				end else if (tmr_full) begin
					nxt_state = segway_sense_pkg::STEER_EN;
					en_steer = 1'b1;	// enable already on the transition
				end
			end
			segway_sense_pkg::STEER_EN: begin
				en_steer = 1'b1;
				if (sum_lt_min) begin
					nxt_state = segway_sense_pkg::IDLE;
					rider_off = 1'b1;
				end else if (diff_gt_15_16) begin
					nxt_state = segway_sense_pkg::WAIT;
					clr_tmr = 1'b1;
				end
			end
			default: begin	// IDLE
				if (sum_gt_min) begin
					nxt_state = segway_sense_pkg::WAIT;
					clr_tmr = 1'b1;
				end
			end
		endcase
	end

	no_steer_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
		state == segway_sense_pkg::IDLE |-> !en_steer);

endmodule

//--- segway_sense.sv
`timescale 1ns/1ps
module segway_sense #(
	parameter bit fast_sim = 1'b0
) (
	input  logic clk,
	input  logic rst_n,
	output logic ss_n,								// a2d spi pins
	output logic sclk,
	output logic mosi,
	input  logic miso,
	output segway_sense_pkg::ld_t ld_cell_diff,
	output logic ld_vld,
	output logic en_steer,
	output logic rider_off,
	output logic batt_low
);

	logic ld_req, batt_req;				// requester levels into the arbiter
	logic ld_done, batt_done;			// done routed back to the owner
	logic strt, done;					// arbiter to spi master
	segway_sense_pkg::a2d_req_t ld_chnl, batt_chnl, a2d_req;
	segway_sense_pkg::ld_t res;			// shared result, each side takes it on its own done
	segway_sense_pkg::ld_t lft_ld, rght_ld;

	ld_cell_poll u_ld_cell_poll (
		.clk(clk), .rst_n(rst_n),
		.req(ld_req), .chnl(ld_chnl), .done(ld_done), .res(res),
		.lft_ld(lft_ld), .rght_ld(rght_ld), .ld_vld(ld_vld)
	);

	batt_mon u_batt_mon (
		.clk(clk), .rst_n(rst_n),
		.req(batt_req), .chnl(batt_chnl), .done(batt_done), .res(res),
		.batt_low(batt_low)
	);

	a2d_arbiter u_a2d_arbiter (
		.clk(clk), .rst_n(rst_n),
		.ld_req(ld_req), .batt_req(batt_req),
		.ld_chnl(ld_chnl), .batt_chnl(batt_chnl),
		.strt(strt), .req(a2d_req), .done(done),
		.ld_done(ld_done), .batt_done(batt_done)
	);

	a2d_spi u_a2d_spi (
		.clk(clk), .rst_n(rst_n),
		.strt(strt), .req(a2d_req),
		.ss_n(ss_n), .sclk(sclk), .mosi(mosi), .miso(miso),
		.done(done), .res(res)
	);

	steer_en #(.fast_sim(fast_sim)) u_steer_en (
		.clk(clk), .rst_n(rst_n),
		.lft_ld(lft_ld), .rght_ld(rght_ld),
		.ld_cell_diff(ld_cell_diff), .en_steer(en_steer), .rider_off(rider_off)
	);

endmodule

//--- adc_model.sv
`timescale 1ns/1ps
module adc_model (
	input  logic ss_n,
	input  logic sclk,
	input  logic mosi,
	output logic miso,
	input  segway_sense_pkg::ld_t [7:0] chnl_vals	// conversion result per channel
);

	segway_sense_pkg::ld_t [7:0] snap;		// frozen at frame start so one frame never mixes values
	segway_sense_pkg::ld_t cur_val;
	segway_sense_pkg::chnl_t chnl_lat;		// full channel once bit 11 is in
	segway_sense_pkg::chnl_t chnl_now;
	logic [1:0] cmd_hi = '0;				// last two mosi bits, bits 13 and 12 after 4 edges
	logic [4:0] bit_idx = '0;				// rising sclk edges seen so far in this frame

	always @(negedge ss_n)
		snap <= chnl_vals;

	always @(posedge sclk or posedge ss_n) begin
		if (ss_n) begin
			bit_idx <= '0;	// deselected, wait for next frame
		end else begin
			cmd_hi <= {cmd_hi[0], mosi};
			if (bit_idx == 5'd4)
				chnl_lat <= {cmd_hi, mosi};	// bits 13..11
			bit_idx <= bit_idx + 5'd1;
		end
	end

	// result bit 11 leaves in the same period as the last channel bit,
	// so in that period the channel comes straight from mosi
	assign chnl_now = (bit_idx == 5'd4) ? {cmd_hi, mosi} : chnl_lat;
	assign cur_val = snap[chnl_now];

	// four leading zeros, then result bits 11..0
	assign miso = (!ss_n && bit_idx >= 5'd4 && bit_idx <= 5'd15) ?
		cur_val[4'd15 - bit_idx[3:0]] : 1'b0;

endmodule

//--- tb_segway_sense.sv
`timescale 1ns/1ps
module tb_segway_sense;

	localparam int FRAME = 68;			// clk cycles per conversion, idle cycle included
	localparam int UPDATE = 4 * FRAME;	// worst case for a fresh reading when sharing the bus
	localparam int SETTLE = 32768;		// fast_sim settle period
	localparam int BATT_WAIT = segway_sense_pkg::BATT_PERIOD + 3 * FRAME;
	localparam int N_PAIRS = 8;
	localparam int CLEAR = 2 * UPDATE + 4;
	localparam int TIMEOUT = 8 + N_PAIRS * 2 * UPDATE	// reset and difference pairs
		+ CLEAR + SETTLE + UPDATE						// light load
		+ 2 * CLEAR + SETTLE + UPDATE					// balanced rider
		+ 2 * CLEAR + 3 * SETTLE + 4 * UPDATE			// unbalanced rider
		+ 5 * BATT_WAIT									// battery windows
		+ SETTLE / 2;									// margin

	logic clk;
	logic rst_n;
	logic ss_n, sclk, mosi, miso;
	segway_sense_pkg::ld_t ld_cell_diff;
	logic ld_vld, en_steer, rider_off, batt_low;
	segway_sense_pkg::ld_t [7:0] chnl_vals;	// what the a2d model returns per channel
	int vld_cnt = 0;	// ld_vld pulses seen
	int off_cnt = 0;	// rider_off pulses seen
	int cyc_cnt = 0;

	segway_sense #(.fast_sim(1'b1)) u_segway_sense (
		.clk(clk), .rst_n(rst_n),
		.ss_n(ss_n), .sclk(sclk), .mosi(mosi), .miso(miso),
		.ld_cell_diff(ld_cell_diff), .ld_vld(ld_vld), .en_steer(en_steer),
		.rider_off(rider_off), .batt_low(batt_low)
	);

	adc_model u_adc_model (
		.ss_n(ss_n), .sclk(sclk), .mosi(mosi), .miso(miso), .chnl_vals(chnl_vals)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt > TIMEOUT)
			abort_run($sformatf("Timeout: tests still running after %0d clock cycles", TIMEOUT));
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0d ns: %s, expected %0h, got %0h", $time, what, exp, got);
			abort_run("first mismatch ends the run");
		end
	endtask

	// one clock, inputs change and pulses get counted on the falling edge
	task automatic step_cycle();
		@(negedge clk);
		if (ld_vld)
			vld_cnt++;
		if (rider_off)
			off_cnt++;
	endtask

	// bus parked and all flags quiet while reset is held
	task automatic check_reset_values();
		check_value("ss_n in reset", 32'(ss_n), 32'd1);
		check_value("sclk in reset", 32'(sclk), 32'd1);
		check_value("ld_vld in reset", 32'(ld_vld), 32'd0);
		check_value("en_steer in reset", 32'(en_steer), 32'd0);
		check_value("rider_off in reset", 32'(rider_off), 32'd0);
		check_value("batt_low in reset", 32'(batt_low), 32'd0);
		check_value("ld_cell_diff in reset", 32'(ld_cell_diff), 32'd0);
	endtask

	task automatic wait_ld_vld(input int n);
		int start;
		int guard;
		start = vld_cnt;
		guard = 0;
		while (vld_cnt < start + n) begin
			step_cycle();
			guard++;
			if (guard > n * UPDATE)
				abort_run("ld_vld stopped pulsing, load readings are not refreshed");
		end
	endtask

	task automatic drive_loads(input segway_sense_pkg::ld_t lft, input segway_sense_pkg::ld_t rght);
		chnl_vals[segway_sense_pkg::LFT_CHNL] = lft;
		chnl_vals[segway_sense_pkg::RGHT_CHNL] = rght;
	endtask

	task automatic settle_loads(input segway_sense_pkg::ld_t lft, input segway_sense_pkg::ld_t rght);
		drive_loads(lft, rght);
		wait_ld_vld(2);		// second pair is fresh on both sides
		repeat (3) step_cycle();
	endtask

	// wait until en_steer rises or the settle bound runs out, counted from start
	task automatic wait_steer_on(input int start);
		int i;
		i = start;
		while (!en_steer && i < SETTLE + UPDATE) begin
			step_cycle();
			i++;
		end
		check_value("en_steer after settle period", 32'(en_steer), 32'd1);
	endtask

	task automatic diff_follows_loads();
		segway_sense_pkg::ld_t lft, rght, exp;
		for (int i = 0; i < N_PAIRS; i++) begin
			lft = (i == 1) ? 12'hFFF : 12'($urandom);
			rght = (i == 0) ? 12'hFFF : 12'($urandom);
			if (i < 2)
				lft = (i == 0) ? 12'h000 : lft;	// both wrap corners first
			if (i == 1)
				rght = 12'h000;
			exp = lft - rght;	// modulo 4096
			drive_loads(lft, rght);
			wait_ld_vld(2);
			check_value("ld_cell_diff", 32'(ld_cell_diff), 32'(exp));
		end
	endtask

	task automatic light_load_no_steer();
		int off0;
		settle_loads(12'h000, 12'h000);
		off0 = off_cnt;
		drive_loads(12'h100, 12'h100);	// sum right at the minimum, not above
		repeat (SETTLE + UPDATE) begin
			step_cycle();
			check_value("en_steer under light load", 32'(en_steer), 32'd0);
		end
		check_value("rider_off pulses under light load", off_cnt - off0, 32'd0);
	endtask

	task automatic balanced_rider();
		int off0;
		settle_loads(12'h000, 12'h000);
		off0 = off_cnt;
		drive_loads(12'h400, 12'h400);
		repeat (30000) begin
			step_cycle();
			check_value("en_steer before settle", 32'(en_steer), 32'd0);
		end
		wait_steer_on(30000);
		settle_loads(12'h000, 12'h000);	// rider steps off
		check_value("rider_off pulses on leaving", off_cnt - off0, 32'd1);
		check_value("en_steer after leaving", 32'(en_steer), 32'd0);
	endtask

	task automatic unbalanced_rider();
		int off0;
		settle_loads(12'h000, 12'h000);
		off0 = off_cnt;
		drive_loads(12'h500, 12'h200);	// diff 0x300 over quarter 0x1C0
		repeat (2 * SETTLE) begin
			step_cycle();
			check_value("en_steer with off-center rider", 32'(en_steer), 32'd0);
		end
		drive_loads(12'h400, 12'h400);
		wait_steer_on(0);
		drive_loads(12'h600, 12'h200);	// diff 0x400, between 0x200 and 0x780
		repeat (3 * UPDATE) begin
			step_cycle();
			check_value("en_steer while leaning", 32'(en_steer), 32'd1);
		end
		check_value("ld_cell_diff while leaning", 32'(ld_cell_diff), 32'h400);
		settle_loads(12'h700, 12'h000);	// diff 0x700 over 0x690
		check_value("en_steer when stepping off one side", 32'(en_steer), 32'd0);
		check_value("rider_off with weight still on", off_cnt - off0, 32'd0);
	endtask

	// one battery window, flag must reach exp_low and then stay there
	task automatic batt_window(input segway_sense_pkg::ld_t val, input logic exp_low);
		int vld0;
		logic seen;
		vld0 = vld_cnt;
		seen = 1'b0;
		chnl_vals[segway_sense_pkg::BATT_CHNL] = val;
		repeat (BATT_WAIT) begin
			step_cycle();
			seen |= (batt_low === exp_low);
			if (seen)
				check_value("batt_low held", 32'(batt_low), 32'(exp_low));
		end
		check_value("batt_low reached", 32'(seen), 32'd1);
		check_value("ld_vld during battery window", 32'(vld_cnt > vld0), 32'd1);	// both served
	endtask

	task automatic battery_flag();
		check_value("batt_low with healthy battery", 32'(batt_low), 32'd0);
		batt_window(12'h900, 1'b1);	// below on threshold
		batt_window(12'hA00, 1'b0);	// off threshold exactly
		batt_window(12'h980, 1'b0);	// inside band, stays clear
		batt_window(12'h900, 1'b1);
		batt_window(12'h9FF, 1'b1);	// inside band, stays set
	endtask

	initial begin
		void'($urandom(40084));
		rst_n = 1'b0;
		chnl_vals = '0;
		chnl_vals[segway_sense_pkg::BATT_CHNL] = 12'hC00;	// healthy battery
		repeat (8) @(negedge clk);
		check_reset_values();
		rst_n = 1'b1;
		diff_follows_loads();
		light_load_no_steer();
		balanced_rider();
		unbalanced_rider();
		battery_flag();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- segway_sense.f
segway_sense_pkg.sv
a2d_spi.sv
a2d_arbiter.sv
ld_cell_poll.sv
batt_mon.sv
steer_en.sv
segway_sense.sv
adc_model.sv
tb_segway_sense.sv

//--- run_sim.sh
#!/bin/sh
# build the simulation with verilator, run it, and judge the log
verilator --binary --timing --assert --top-module tb_segway_sense -f segway_sense.f \
	> build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_segway_sense > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || exit 1
exit 0
